//--- src/dz_pkg.sv
package dz_pkg;

    localparam int DEBOUNCE_CYCLES = 16;             // Equal samples before a key level is taken
    localparam int DB_CNT_W = 5;
    localparam int SCAN_DIV = 4;                     // clk cycles per matrix row
    localparam int SCAN_CNT_W = 2;
    localparam int SEC_DIV = 64;                     // Row strobes per second, eight frames
    localparam int SEC_CNT_W = 6;
    localparam int ROWS = 8;
    localparam int ROW_W = 3;
    localparam int DIGIT_W = 3;
    localparam logic [DIGIT_W-1:0] START_DIGIT = 3'd7;

    // Red column word for one row of a digit, rows not listed stay dark
    function automatic logic [7:0] glyph_red(
        input logic [DIGIT_W-1:0] digit,
        input logic [ROW_W-1:0]   row_idx
    );
        logic [7:0] cols;
        case ({digit, row_idx})
            {3'd7, 3'd1}, {3'd7, 3'd2}:               cols = 8'b0010_0010;
            {3'd6, 3'd0}:                             cols = 8'b0111_1000;
            {3'd6, 3'd1}:                             cols = 8'b1100_1100;
            {3'd6, 3'd2}:                             cols = 8'b0000_1100;
            {3'd6, 3'd3}:                             cols = 8'b0001_1000;
            {3'd6, 3'd4}, {3'd6, 3'd6}:               cols = 8'b0011_0000;
            {3'd5, 3'd1}:                             cols = 8'b0111_1110;
            {3'd5, 3'd2}:                             cols = 8'b0110_0000;
            {3'd5, 3'd3}:                             cols = 8'b0111_1100;
            {3'd5, 3'd4}, {3'd5, 3'd5}:               cols = 8'b0000_0110;
            {3'd5, 3'd6}:                             cols = 8'b0110_0110;
            {3'd5, 3'd7}:                             cols = 8'b0011_1100;
            {3'd4, 3'd1}, {3'd4, 3'd6}, {3'd4, 3'd7}: cols = 8'b0000_1100;
            {3'd4, 3'd2}:                             cols = 8'b0001_1100;
            {3'd4, 3'd3}:                             cols = 8'b0010_1100;
            {3'd4, 3'd4}:                             cols = 8'b0100_1100;
            {3'd4, 3'd5}:                             cols = 8'b0111_1110;
            {3'd3, 3'd1}, {3'd3, 3'd7}:               cols = 8'b0011_1100;
            {3'd3, 3'd2}, {3'd3, 3'd6}:               cols = 8'b0110_0110;
            {3'd3, 3'd3}, {3'd3, 3'd5}:               cols = 8'b0000_0110;
            {3'd3, 3'd4}:                             cols = 8'b0001_1100;
            {3'd2, 3'd1}:                             cols = 8'b0011_1100;
            {3'd2, 3'd2}:                             cols = 8'b0110_0110;
            {3'd2, 3'd3}:                             cols = 8'b0000_0110;
            {3'd2, 3'd4}:                             cols = 8'b0000_1100;
            {3'd2, 3'd5}:                             cols = 8'b0011_0000;
            {3'd2, 3'd6}:                             cols = 8'b0110_0000;
            {3'd2, 3'd7}:                             cols = 8'b0111_1110;
            default:                                  cols = 8'b0000_0000;
        endcase
        return cols;
    endfunction

    // Green column word, digits 3 and 2 are yellow and reuse the red shape
    function automatic logic [7:0] glyph_green(
        input logic [DIGIT_W-1:0] digit,
        input logic [ROW_W-1:0]   row_idx
    );
        logic [7:0] cols;
        case ({digit, row_idx})
            {3'd7, 3'd1}:                             cols = 8'b0010_0010;
            {3'd7, 3'd2}:                             cols = 8'b0111_0111;
            {3'd1, 3'd1}, {3'd1, 3'd2}, {3'd1, 3'd4}: cols = 8'b0001_1000;
            {3'd1, 3'd5}, {3'd1, 3'd6}:               cols = 8'b0001_1000;
            {3'd1, 3'd3}:                             cols = 8'b0011_1000;
            {3'd1, 3'd7}:                             cols = 8'b0111_1110;
            {3'd0, 3'd1}, {3'd0, 3'd7}:               cols = 8'b0011_1100;
            {3'd0, 3'd2}, {3'd0, 3'd3}, {3'd0, 3'd4}: cols = 8'b0100_0010;
            {3'd0, 3'd5}, {3'd0, 3'd6}:               cols = 8'b0100_0010;
            default:
                cols = (digit == 3'd3 || digit == 3'd2) ? glyph_red(digit, row_idx) : 8'b0000_0000;
        endcase
        return cols;
    endfunction

endpackage

//--- src/key_debounce.sv
`timescale 1ns/1ps

module key_debounce (
    input  logic clk,
    input  logic rst,
    input  logic key,
    output logic start_pulse
);
    import dz_pkg::*;

    logic                key_meta;
    logic                key_sync;
    logic                key_level;
    logic [DB_CNT_W-1:0] stable_cnt;
    logic                accept;

    // The last of DEBOUNCE_CYCLES differing samples flips the accepted level
    assign accept = (key_sync != key_level) &&
                    (stable_cnt == DB_CNT_W'(DEBOUNCE_CYCLES - 1));

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            key_meta    <= 1'b0;
            key_sync    <= 1'b0;
            key_level   <= 1'b0;
            stable_cnt  <= '0;
            start_pulse <= 1'b0;
        end
        else
        begin
            key_meta    <= key;
            key_sync    <= key_meta;
            start_pulse <= accept && key_sync;                 // Only a press, never a release
            if (key_sync == key_level)
                stable_cnt <= '0;                              // Bounce back restarts the wait
            else if (accept)
            begin
                stable_cnt <= '0;
                key_level  <= key_sync;
            end
            else
                stable_cnt <= stable_cnt + 1'b1;
        end
    end

    // One accepted rise must be followed by a full debounce before the next
    a_single_strobe: assert property (
        @(posedge clk) disable iff (rst) start_pulse |=> !start_pulse
    );

endmodule

//--- src/tick_gen.sv
`timescale 1ns/1ps

module tick_gen (
    input  logic clk,
    input  logic rst,
    input  logic start_pulse,
    output logic scan_tick,
    output logic sec_tick
);
    import dz_pkg::*;

    logic [SCAN_CNT_W-1:0] scan_cnt;
    logic [SEC_CNT_W-1:0]  sec_cnt;
    logic                  scan_due;
    logic                  sec_due;

    // Strobes are raised one count early so they sit on the wrap cycle
    assign scan_due = (scan_cnt == SCAN_CNT_W'(SCAN_DIV - 2));
    assign sec_due  = scan_due && (sec_cnt == SEC_CNT_W'(SEC_DIV - 1));

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            scan_cnt  <= '0;
            sec_cnt   <= '0;
            scan_tick <= 1'b0;
            sec_tick  <= 1'b0;
        end
        else if (start_pulse)
        begin
            scan_cnt  <= '0;                                   // Countdown starts on a clean second
            sec_cnt   <= '0;
            scan_tick <= 1'b0;
            sec_tick  <= 1'b0;
        end
        else
        begin
            scan_tick <= scan_due;
            sec_tick  <= sec_due;
            if (scan_cnt == SCAN_CNT_W'(SCAN_DIV - 1))
                scan_cnt <= '0;
            else
                scan_cnt <= scan_cnt + 1'b1;
            if (sec_due)
                sec_cnt <= '0;
            else if (scan_due)
                sec_cnt <= sec_cnt + 1'b1;
        end
    end

    a_sec_on_scan: assert property (
        @(posedge clk) disable iff (rst) sec_tick |-> scan_tick
    );

endmodule

//--- src/countdown_ctrl.sv
`timescale 1ns/1ps

module countdown_ctrl (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       start_pulse,
    input  logic                       sec_tick,
    output logic [dz_pkg::DIGIT_W-1:0] digit,
    output logic                       active,
    output logic                       done
);
    import dz_pkg::*;

    logic step;
    logic last_step;

    // A second only counts while a countdown is running and not finished
    assign step      = sec_tick && active && (digit != '0);
    assign last_step = (digit == DIGIT_W'(1));

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            digit  <= START_DIGIT;
            active <= 1'b0;
            done   <= 1'b0;
        end
        else if (start_pulse)
        begin
            digit  <= START_DIGIT;                             // Restart wins over a second tick
            active <= 1'b1;
            done   <= 1'b0;
        end
        else if (step)
        begin
            digit <= digit - 1'b1;
            if (last_step)
                done <= 1'b1;                                  // Raised on the edge that shows 0
        end
    end

    // The flag and the shown digit must never disagree, even for a cycle
    a_done_at_zero: assert property (
        @(posedge clk) disable iff (rst) done == (active && digit == '0)
    );

endmodule

//--- src/dz_show.sv
`timescale 1ns/1ps

module dz_show (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       active,
    input  logic                       scan_tick,
    input  logic [dz_pkg::DIGIT_W-1:0] digit,
    output logic [7:0]                 row,
    output logic [7:0]                 colr,
    output logic [7:0]                 colg
);
    import dz_pkg::*;

    localparam logic [ROW_W-1:0] ROW_PARK = ROW_W'(ROWS - 1);

    logic [ROW_W-1:0]   row_idx;
    logic [ROW_W-1:0]   next_idx;
    logic [DIGIT_W-1:0] frame_digit;
    logic [DIGIT_W-1:0] show_digit;
    logic               advance;
    logic               frame_start;

    assign advance     = scan_tick && active;
    assign next_idx    = (row_idx == ROW_PARK) ? '0 : row_idx + 1'b1;
    assign frame_start = (next_idx == '0);

    // Row 0 takes the live digit, the rest of the frame reuses that copy
    assign show_digit = frame_start ? digit : frame_digit;

    always_ff @(posedge clk)
    begin
        if (advance && frame_start)
            frame_digit <= digit;
    end

    // Parking on the last index makes the first strobe land on row 0
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            row_idx <= ROW_PARK;
        else if (!active)
            row_idx <= ROW_PARK;
        else if (scan_tick)
            row_idx <= next_idx;
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            row  <= 8'hff;
            colr <= 8'h00;
            colg <= 8'h00;
        end
        else if (!active)
        begin
            row  <= 8'hff;                                     // Blank matrix between countdowns
            colr <= 8'h00;
            colg <= 8'h00;
        end
        else if (scan_tick)
        begin
            row  <= ~(8'b0000_0001 << next_idx);               // Active low row select
            colr <= glyph_red(show_digit, next_idx);
            colg <= glyph_green(show_digit, next_idx);
        end
    end

    a_one_row: assert property (
        @(posedge clk) disable iff (rst) $countones(~row) <= 1
    );

endmodule

//--- src/countdown_display_top.sv
`timescale 1ns/1ps

module countdown_display_top (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       key,
    output logic [7:0]                 row,
    output logic [7:0]                 colr,
    output logic [7:0]                 colg,
    output logic [dz_pkg::DIGIT_W-1:0] digit,
    output logic                       done
);

    logic start_pulse;
    logic scan_tick;
    logic sec_tick;
    logic active;

    key_debounce u_key_debounce (
        .clk         (clk),
        .rst         (rst),
        .key         (key),
        .start_pulse (start_pulse)
    );

    tick_gen u_tick_gen (
        .clk         (clk),
        .rst         (rst),
        .start_pulse (start_pulse),
        .scan_tick   (scan_tick),
        .sec_tick    (sec_tick)
    );

    countdown_ctrl u_countdown_ctrl (
        .clk         (clk),
        .rst         (rst),
        .start_pulse (start_pulse),
        .sec_tick    (sec_tick),
        .digit       (digit),
        .active      (active),
        .done        (done)
    );

    dz_show u_dz_show (
        .clk       (clk),
        .rst       (rst),
        .active    (active),
        .scan_tick (scan_tick),
        .digit     (digit),
        .row       (row),
        .colr      (colr),
        .colg      (colg)
    );

endmodule

//--- tb/tb_countdown_display.sv
`timescale 1ns/1ps

module tb_countdown_display;
    import dz_pkg::*;

    localparam int SEC_CYCLES    = SCAN_DIV * SEC_DIV;
    localparam int PRESS_LATENCY = DEBOUNCE_CYCLES + 2;       // Clean key edge to start strobe
    localparam int GLITCHES      = 6;

    logic               clk = 1'b0;
    logic               rst;
    logic               key;
    logic [7:0]         row;
    logic [7:0]         colr;
    logic [7:0]         colg;
    logic [DIGIT_W-1:0] digit;
    logic               done;

    logic [31:0]        lfsr;
    int                 edge_no = 0;
    int                 start_edge = 1_000_000_000;
    int                 sec_count = 0;
    logic [DIGIT_W-1:0] model_digit = START_DIGIT;
    logic [DIGIT_W-1:0] prev_digit = START_DIGIT;
    logic               model_active = 1'b0;
    logic               interval_free = 1'b0;
    logic [7:0]         last_row = 8'hff;
    logic [ROW_W-1:0]   row_idx = '0;
    logic [DIGIT_W-1:0] frame_digit = '0;
    int                 since_change = 0;
    logic [7:0]         digits_seen = 8'h00;

    countdown_display_top DUT (
        .clk   (clk),
        .rst   (rst),
        .key   (key),
        .row   (row),
        .colr  (colr),
        .colg  (colg),
        .digit (digit),
        .done  (done)
    );

    always #2 clk = ~clk;

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
    function automatic int take_bits(input int count);
        int   value;
        logic fb;
        value = 0;
        for (int i = 0; i < count; i++)
        begin
            fb    = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr  = {lfsr[30:0], fb};
            value = (value << 1) | lfsr[0];
        end
        return value;
    endfunction

    // Red word in the upper byte, green word in the lower byte
    function automatic logic [15:0] expected_cols(input logic [DIGIT_W-1:0] d,
                                                  input logic [ROW_W-1:0] r);
        return {glyph_red(d, r), glyph_green(d, r)};
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected)
        begin
            $display("MISMATCH %s: got 0x%0h, expected 0x%0h at %0t", name, actual, expected,
                     $time);
            $display("Simulation FAILED");
            $fatal(1, "stopped at the first error");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("TIMEOUT: %s at %0t", what, $time);
        $display("Simulation FAILED");
        $fatal(1, "stopped on a timeout");
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    // Key goes high 1 ns after an edge, the strobe follows PRESS_LATENCY edges later
    task automatic press_key();
        @(posedge clk);
        #1;
        key        = 1'b1;
        start_edge = edge_no + PRESS_LATENCY;
    endtask

    // Model state after each rising edge
    always @(posedge clk)
    begin
        edge_no    = edge_no + 1;
        prev_digit = model_digit;
        if (edge_no == start_edge + 1)
        begin
            model_digit   = 3'd7;
            model_active  = 1'b1;
            sec_count     = 0;
            interval_free = 1'b1;                            // Scan phase may jump at a start
        end
        else if (model_active)
        begin
            sec_count = sec_count + 1;
            if (sec_count == SEC_CYCLES)
            begin
                sec_count = 0;
                if (model_digit != 0)
                    model_digit = model_digit - 1'b1;
            end
        end
    end

    // Outputs settle after the rising edge, so they are compared on the falling one
    always @(negedge clk)
    begin
        logic [7:0]  exp_row;
        logic [15:0] exp_cols;
        if (!rst)
        begin
            check_value("digit", digit, model_digit);
            check_value("done", done, model_active && (model_digit == 0));
            if (!model_active)
            begin
                check_value("row", row, 8'hff);
                check_value("colr", colr, 8'h00);
                check_value("colg", colg, 8'h00);
                since_change = 0;
            end
            else if (row != last_row)
            begin
                if (last_row != 8'hff && !interval_free)
                    check_value("row period", since_change, SCAN_DIV);
                interval_free = 1'b0;
                row_idx       = (last_row == 8'hff) ? '0 : row_idx + 1'b1;
                if (row_idx == 0)
                    frame_digit = prev_digit;                // Row 0 picks up the digit of its frame
                exp_row  = ~(8'h01 << row_idx);
                exp_cols = expected_cols(frame_digit, row_idx);
                check_value("row", row, exp_row);
                check_value("colr", colr, exp_cols[15:8]);
                check_value("colg", colg, exp_cols[7:0]);
                digits_seen[frame_digit] = 1'b1;
                since_change = 1;
                last_row     = row;
            end
            else
            begin
                since_change = since_change + 1;
                if (since_change > 2 * SCAN_DIV)
                    report_timeout("row scan stopped advancing while active");
            end
        end
    end

    initial
    begin
        int n;
        int width;
        key  = 1'b0;
        rst  = 1'b1;
        lfsr = 32'hfd04b0aa;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;

        // Idle display after reset
        wait_cycles(300);
        check_value("row", row, 8'hff);
        check_value("digit", digit, 3'd7);
        check_value("done", done, 1'b0);

        // Short pulses must never start a countdown
        for (int g = 0; g < GLITCHES; g++)
        begin
            wait_cycles(20 + take_bits(5));
            width = 1 + (take_bits(4) % 12);
            key   = 1'b1;
            wait_cycles(width);
            key = 1'b0;
        end
        wait_cycles(40);

        press_key();
        n = 0;
        while (row == 8'hff)
        begin
            @(negedge clk);
            n++;
            if (n > PRESS_LATENCY + SCAN_DIV + 8)
                report_timeout("matrix never left blank after a key press");
        end
        check_value("first row edge", edge_no, start_edge + SCAN_DIV + 1);
        wait_cycles(8);
        key = 1'b0;

        // Second press lands somewhere in the third or fourth second
        wait_cycles(2 * SEC_CYCLES + take_bits(9));
        press_key();
        n = 0;
        while (digit != 3'd7)
        begin
            @(negedge clk);
            n++;
            if (n > PRESS_LATENCY + 8)
                report_timeout("digit never returned to 7 after a restart");
        end
        check_value("restart edge", edge_no, start_edge + 1);
        wait_cycles(30);
        key = 1'b0;

        n = 0;
        while (!done)
        begin
            @(negedge clk);
            n++;
            if (n > 8 * SEC_CYCLES)
                report_timeout("done never rose after the restart");
        end
        check_value("digit at done", digit, 3'd0);

        // Zero stays on the matrix for two more seconds
        wait_cycles(2 * SEC_CYCLES);
        check_value("digit", digit, 3'd0);
        check_value("done", done, 1'b1);
        check_value("digits shown", digits_seen, 8'hff);

        $display("Simulation PASSED");
        $finish;
    end

endmodule

//--- src.f
src/dz_pkg.sv
src/key_debounce.sv
src/tick_gen.sv
src/countdown_ctrl.sv
src/dz_show.sv
src/countdown_display_top.sv
tb/tb_countdown_display.sv
